/* ex_top.f */
+incdir+source
source/mips_pkg.sv
source/forwarding_unit.sv
source/alu_control.sv
source/alu.sv
source/branch_resolver.sv
source/ex_stage.sv
source/ex_mem_reg.sv
source/ex_top.sv
test/ex_top_tb.sv

/* Makefile */
TB  = ex_top_tb
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Isource --top-module ex_top \
	  source/mips_pkg.sv source/forwarding_unit.sv source/alu_control.sv \
	  source/alu.sv source/branch_resolver.sv source/ex_stage.sv \
	  source/ex_mem_reg.sv source/ex_top.sv

sim:
	verilator --binary -f ex_top.f --top-module $(TB) -o $(TB)
	./obj_dir/$(TB) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG) || (echo "Simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* test/ex_top_tb.sv */
`timescale 1ns/1ps
`include "mips_settings.svh"

module ex_top_tb
  import mips_pkg::*;
();

  // ID/EX and forwarding inputs seen by the reference model
  typedef struct packed {
    instr_u             instr;
    logic [`DATA_W-1:0] rd1;
    logic [`DATA_W-1:0] rd2;
    logic [`REG_W-1:0]  mem_rd;
    logic [`REG_W-1:0]  wb_rd;
    logic               mem_we;
    logic               wb_we;
    logic [`DATA_W-1:0] mem_val;
    logic [`DATA_W-1:0] wb_val;
    logic               alu_src;
    logic               reg_dst;
    alu_op_e            alu_op;
    logic               branch;
    logic               pred;
  } stim_t;

  typedef struct packed {
    logic [`DATA_W-1:0] alu_result;
    logic [`DATA_W-1:0] store_data;
    logic [`REG_W-1:0]  write_register;
    logic               taken;
    logic               mispred;
  } res_t;

  logic               clk;
  logic               i_rst_n;
  logic               i_stall;
  logic               i_flush;
  logic               i_reg_write, i_mem_read, i_mem_write, i_mem_to_reg;  // Bypass EX
  stim_t              stim;                                // Everything ex_stage consumes
  logic [`DATA_W-1:0] o_alu_result;
  logic [`DATA_W-1:0] o_store_data;
  logic [`REG_W-1:0]  o_write_register;
  logic               o_reg_write, o_mem_read, o_mem_write, o_mem_to_reg, o_branch;
  logic               o_branch_taken;
  logic               o_mispredicted;
  logic [`DATA_W-1:0] exp_alu;                             // Model of the EX/MEM register
  logic [`DATA_W-1:0] exp_store;
  logic [`REG_W-1:0]  exp_wreg;
  logic [4:0]         exp_ctrl;                            // reg_write .. branch
  int                 n_checks, n_errors, n_tests;
  int                 n_driven;                            // Cycles of stimulus applied
  int                 n_covered;                           // Cycles whose registered result was checked
  int                 prev_driven;

  ex_top dut (
    .*,
    .i_instr              (stim.instr),
    .i_read_data_1        (stim.rd1),
    .i_read_data_2        (stim.rd2),
    .i_mem_write_register (stim.mem_rd),
    .i_wb_write_register  (stim.wb_rd),
    .i_mem_reg_write      (stim.mem_we),
    .i_wb_reg_write       (stim.wb_we),
    .i_mem_alu_result     (stim.mem_val),
    .i_wb_write_data      (stim.wb_val),
    .i_alu_src            (stim.alu_src),
    .i_reg_dst            (stim.reg_dst),
    .i_alu_op             (stim.alu_op),
    .i_branch             (stim.branch),
    .i_branch_prediction  (stim.pred)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;                                 // 100 MHz
  end

  // MEM beats WB and $zero always reads the register file
  function automatic logic [`DATA_W-1:0] operand_ref(input logic [`REG_W-1:0] src,
                                                     input logic [`DATA_W-1:0] reg_val,
                                                     input stim_t s);
    if (src == '0) return reg_val;
    if (s.mem_we && (s.mem_rd == src)) return s.mem_val;
    if (s.wb_we && (s.wb_rd == src)) return s.wb_val;
    return reg_val;
  endfunction

  function automatic res_t ex_ref(input stim_t s);
    res_t               r;
    logic [`DATA_W-1:0] a;
    logic [`DATA_W-1:0] b;
    logic [`DATA_W-1:0] bsrc;
    logic [5:0]         code;
    logic [5:0]         op;
    a    = operand_ref(s.instr.r.rs, s.rd1, s);
    b    = operand_ref(s.instr.r.rt, s.rd2, s);
    bsrc = s.alu_src ? `DATA_W'($signed(s.instr.i.imm16)) : b;
    case (s.alu_op)                                        // Fold the class onto a funct code
      ALUOP_ADD: code = `FUNCT_ADD;
      ALUOP_SUB: code = `FUNCT_SUB;
      ALUOP_SLT: code = `FUNCT_SLT;
      default:   code = s.instr.r.funct;
    endcase
    case (code)
      `FUNCT_SUB: r.alu_result = a - bsrc;
      `FUNCT_AND: r.alu_result = a & bsrc;
      `FUNCT_OR:  r.alu_result = a | bsrc;
      `FUNCT_NOR: r.alu_result = ~(a | bsrc);
      `FUNCT_SLT: r.alu_result = ($signed(a) < $signed(bsrc)) ? 32'd1 : 32'd0;
      default:    r.alu_result = a + bsrc;                 // Add and unknown codes
    endcase
    r.store_data     = b;
    r.write_register = s.reg_dst ? s.instr.r.rd : s.instr.i.rt;
    op               = s.instr.i.opcode;
    r.taken   = s.branch && (((op == `OPCODE_BEQ) && (a == b)) ||
                             ((op == `OPCODE_BNE) && (a != b)));
    r.mispred = s.branch && (r.taken != s.pred);
    return r;
  endfunction

  function automatic logic [5:0] funct_at(input logic [2:0] idx);
    case (idx)
      3'd0:    return `FUNCT_ADD;
      3'd1:    return `FUNCT_SUB;
      3'd2:    return `FUNCT_AND;
      3'd3:    return `FUNCT_OR;
      3'd4:    return `FUNCT_NOR;
      3'd5:    return `FUNCT_SLT;
      default: return 6'h3f;                               // Unsupported code
    endcase
  endfunction

  function automatic logic [`REG_W-1:0] reg_pick(input logic [1:0] sel, input stim_t s,
                                                 input logic [`REG_W-1:0] any);
    case (sel)
      2'd0:    return s.mem_rd;
      2'd1:    return s.wb_rd;
      2'd2:    return '0;
      default: return any;
    endcase
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  // Mode 0 reset, 1 ALU, 2 forwarding, 3 branches, 4 stall and flush
  task automatic drive_cycle(input int mode);
    stim_t       s;
    logic [31:0] r;
    logic [31:0] v;
    r         = $urandom;
    v         = $urandom;
    s.instr   = $urandom;
    s.rd1     = $urandom;
    s.rd2     = $urandom;
    s.mem_val = $urandom;
    s.wb_val  = $urandom;
    s.mem_rd  = r[4:0];
    s.wb_rd   = r[9:5];
    s.mem_we  = r[10];
    s.wb_we   = r[11];
    s.alu_src = r[12];
    s.reg_dst = r[13];
    s.alu_op  = alu_op_e'(r[15:14]);
    s.branch  = (mode == 0) || ((mode == 4) && v[9]);
    s.pred    = r[16];
    if (mode == 1) begin
      s.mem_we = 1'b0;                                     // Plain register operands
      s.wb_we  = 1'b0;
      if (s.alu_op == ALUOP_FUNCT) begin
        s.instr.r.opcode = `OPCODE_RTYPE;
        s.instr.r.funct  = funct_at(v[2:0]);
        s.alu_src        = 1'b0;
        s.reg_dst        = 1'b1;
      end
    end else if (mode >= 2) begin
      if (v[1:0] == 2'd0) s.wb_rd = s.mem_rd;              // Same register in MEM and WB
      s.instr.r.rs = reg_pick(v[3:2], s, s.instr.r.rs);
      s.instr.r.rt = reg_pick(v[5:4], s, s.instr.r.rt);
    end
    if (mode == 3) begin
      s.instr.i.opcode = v[6] ? `OPCODE_BEQ : `OPCODE_BNE;
      s.branch         = (v[9:7] != 3'd0);                 // Mostly real branches
      s.alu_op         = ALUOP_SUB;
      s.alu_src        = 1'b0;
      if (v[10]) begin
        s.rd2     = s.rd1;                                 // Equal whichever source wins
        s.mem_val = s.rd1;
        s.wb_val  = s.rd1;
      end
    end
    stim         <= s;
    i_reg_write  <= (mode == 0) || v[11];
    i_mem_read   <= (mode == 0) || v[12];
    i_mem_write  <= (mode == 0) || v[13];
    i_mem_to_reg <= (mode == 0) || v[18];
    i_stall      <= (mode == 0) ? v[14] : ((mode == 4) && v[15]);
    i_flush      <= (mode == 0) ? !v[14] : ((mode == 4) && v[16] && v[17]);
    n_driven++;
  endtask

  task automatic wait_checked();
    int waited;
    waited = 0;
    while (n_covered < n_driven) begin
      @(posedge clk);
      waited++;
      if (waited > 8) begin
        $display("Timeout: registered outputs of the last stimulus were never compared");
        $display("TEST RESULT: FAIL");
        $finish;
      end
    end
  endtask

  task automatic run_test(input string name, input int mode, input int cycles);
    int base_chk;
    int base_err;
    base_chk = n_checks;
    base_err = n_errors;
    for (int i = 0; i < cycles; i++) begin
      @(posedge clk);
      drive_cycle(mode);
    end
    wait_checked();
    n_tests++;
    $display("%-12s finished: %0d checks, %0d errors", name, n_checks - base_chk,
             n_errors - base_err);
  endtask

  // Registered outputs against the edge before, flags against this cycle
  always @(negedge clk) begin : compare_outputs
    stim_t s;
    res_t  r;
    s = stim;
    r = ex_ref(s);
    check_val("o_alu_result", o_alu_result, exp_alu);
    check_val("o_store_data", o_store_data, exp_store);
    check_val("o_write_register", 32'(o_write_register), 32'(exp_wreg));
    check_val("o_reg_write", 32'(o_reg_write), 32'(exp_ctrl[4]));
    check_val("o_mem_read", 32'(o_mem_read), 32'(exp_ctrl[3]));
    check_val("o_mem_write", 32'(o_mem_write), 32'(exp_ctrl[2]));
    check_val("o_mem_to_reg", 32'(o_mem_to_reg), 32'(exp_ctrl[1]));
    check_val("o_branch", 32'(o_branch), 32'(exp_ctrl[0]));
    check_val("o_branch_taken", 32'(o_branch_taken), 32'(r.taken));
    check_val("o_mispredicted", 32'(o_mispredicted), 32'(r.mispred));
    if (!i_rst_n) begin
      exp_alu   = '0;
      exp_store = '0;
      exp_wreg  = '0;
      exp_ctrl  = '0;
    end else if (i_flush) begin
      exp_ctrl  = '0;                                      // Bubble keeps the payload
    end else if (!i_stall) begin
      exp_alu   = r.alu_result;
      exp_store = r.store_data;
      exp_wreg  = r.write_register;
      exp_ctrl  = {i_reg_write, i_mem_read, i_mem_write, i_mem_to_reg, s.branch};
    end
    n_covered   = prev_driven;
    prev_driven = n_driven;
  end

  initial begin
    void'($urandom(20117));
    i_rst_n      = 1'b0;
    i_stall      = 1'b1;                                   // First edge after release holds
    i_flush      = 1'b0;
    i_reg_write  = 1'b1;
    i_mem_read   = 1'b1;
    i_mem_write  = 1'b1;
    i_mem_to_reg = 1'b1;
    stim         = '0;
    {exp_alu, exp_store, exp_wreg, exp_ctrl} = '0;
    {n_checks, n_errors, n_tests, n_driven, n_covered, prev_driven} = '0;
    repeat (3) @(posedge clk);                             // Reset over three edges
    i_rst_n <= 1'b1;
    run_test("reset", 0, 3);
    run_test("alu_ops", 1, 400);
    run_test("forwarding", 2, 400);
    run_test("branches", 3, 400);
    run_test("stall_flush", 4, 400);
    $display("Summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* source/ex_top.sv */
`timescale 1ns/1ps
`include "mips_settings.svh"

module ex_top
  import mips_pkg::*;
(
  input  logic               clk,
  input  logic               i_rst_n,
  input  logic               i_stall,                // From hazard unit
  input  logic               i_flush,                // From hazard unit
  input  instr_u             i_instr,
  input  logic [`DATA_W-1:0] i_read_data_1,
  input  logic [`DATA_W-1:0] i_read_data_2,
  input  logic [`REG_W-1:0]  i_mem_write_register,
  input  logic [`REG_W-1:0]  i_wb_write_register,
  input  logic               i_mem_reg_write,
  input  logic               i_wb_reg_write,
  input  logic [`DATA_W-1:0] i_mem_alu_result,
  input  logic [`DATA_W-1:0] i_wb_write_data,
  input  logic               i_alu_src,
  input  logic               i_reg_dst,
  input  alu_op_e            i_alu_op,
  input  logic               i_branch,
  input  logic               i_branch_prediction,
  input  logic               i_reg_write,            // Memory and WB controls, bypass EX
  input  logic               i_mem_read,
  input  logic               i_mem_write,
  input  logic               i_mem_to_reg,
  output logic [`DATA_W-1:0] o_alu_result,           // Registered toward MEM
  output logic [`DATA_W-1:0] o_store_data,
  output logic [`REG_W-1:0]  o_write_register,
  output logic               o_reg_write,
  output logic               o_mem_read,
  output logic               o_mem_write,
  output logic               o_mem_to_reg,
  output logic               o_branch,
  output logic               o_branch_taken,         // Same cycle, for fetch redirect
  output logic               o_mispredicted
);

  logic [`DATA_W-1:0] ex_alu_result;
  logic [`DATA_W-1:0] ex_store_data;
  logic [`REG_W-1:0]  ex_write_register;

  ex_stage u_ex_stage (
    .i_instr              (i_instr),
    .i_read_data_1        (i_read_data_1),
    .i_read_data_2        (i_read_data_2),
    .i_mem_write_register (i_mem_write_register),
    .i_wb_write_register  (i_wb_write_register),
    .i_mem_reg_write      (i_mem_reg_write),
    .i_wb_reg_write       (i_wb_reg_write),
    .i_mem_alu_result     (i_mem_alu_result),
    .i_wb_write_data      (i_wb_write_data),
    .i_alu_src            (i_alu_src),
    .i_reg_dst            (i_reg_dst),
    .i_alu_op             (i_alu_op),
    .i_branch             (i_branch),
    .i_branch_prediction  (i_branch_prediction),
    .o_alu_result         (ex_alu_result),
    .o_store_data         (ex_store_data),
    .o_write_register     (ex_write_register),
    .o_branch_taken       (o_branch_taken),
    .o_mispredicted       (o_mispredicted)
  );

  ex_mem_reg u_ex_mem_reg (
    .clk              (clk),
    .i_rst_n          (i_rst_n),
    .i_stall          (i_stall),
    .i_flush          (i_flush),
    .i_alu_result     (ex_alu_result),
    .i_store_data     (ex_store_data),
    .i_write_register (ex_write_register),
    .i_reg_write      (i_reg_write),
    .i_mem_read       (i_mem_read),
    .i_mem_write      (i_mem_write),
    .i_mem_to_reg     (i_mem_to_reg),
    .i_branch         (i_branch),
    .o_alu_result     (o_alu_result),
    .o_store_data     (o_store_data),
    .o_write_register (o_write_register),
    .o_reg_write      (o_reg_write),
    .o_mem_read       (o_mem_read),
    .o_mem_write      (o_mem_write),
    .o_mem_to_reg     (o_mem_to_reg),
    .o_branch         (o_branch)
  );

endmodule

/* source/ex_mem_reg.sv */
`timescale 1ns/1ps
`include "mips_settings.svh"

module ex_mem_reg (
  input  logic               clk,
  input  logic               i_rst_n,            // Async, active low
  input  logic               i_stall,            // Hold current contents
  input  logic               i_flush,            // Insert a bubble, beats stall
  input  logic [`DATA_W-1:0] i_alu_result,
  input  logic [`DATA_W-1:0] i_store_data,
  input  logic [`REG_W-1:0]  i_write_register,
  input  logic               i_reg_write,
  input  logic               i_mem_read,
  input  logic               i_mem_write,
  input  logic               i_mem_to_reg,
  input  logic               i_branch,
  output logic [`DATA_W-1:0] o_alu_result,
  output logic [`DATA_W-1:0] o_store_data,
  output logic [`REG_W-1:0]  o_write_register,
  output logic               o_reg_write,
  output logic               o_mem_read,
  output logic               o_mem_write,
  output logic               o_mem_to_reg,
  output logic               o_branch
);

  // Control bits, cleared by flush so MEM and WB see a nop
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_reg_write  <= 1'b0;
      o_mem_read   <= 1'b0;
      o_mem_write  <= 1'b0;
      o_mem_to_reg <= 1'b0;
      o_branch     <= 1'b0;
    end else if (i_flush) begin
      o_reg_write  <= 1'b0;              // Bubble
      o_mem_read   <= 1'b0;
      o_mem_write  <= 1'b0;
      o_mem_to_reg <= 1'b0;
      o_branch     <= 1'b0;
    end else if (!i_stall) begin
      o_reg_write  <= i_reg_write;
      o_mem_read   <= i_mem_read;
      o_mem_write  <= i_mem_write;
      o_mem_to_reg <= i_mem_to_reg;
      o_branch     <= i_branch;
    end
  end

  // Data only advances on a normal edge, a bubble keeps the old payload
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_alu_result     <= '0;
      o_store_data     <= '0;
      o_write_register <= '0;
    end else if (!i_stall && !i_flush) begin
      o_alu_result     <= i_alu_result;
      o_store_data     <= i_store_data;
      o_write_register <= i_write_register;
    end
  end

endmodule

/* source/ex_stage.sv */
`timescale 1ns/1ps
`include "mips_settings.svh"

module ex_stage
  import mips_pkg::*;
(
  input  instr_u             i_instr,               // Instruction word from ID/EX
  input  logic [`DATA_W-1:0] i_read_data_1,         // rs from register file
  input  logic [`DATA_W-1:0] i_read_data_2,         // rt from register file
  input  logic [`REG_W-1:0]  i_mem_write_register,  // Destination in MEM
  input  logic [`REG_W-1:0]  i_wb_write_register,   // Destination in WB
  input  logic               i_mem_reg_write,
  input  logic               i_wb_reg_write,
  input  logic [`DATA_W-1:0] i_mem_alu_result,      // Value to forward from MEM
  input  logic [`DATA_W-1:0] i_wb_write_data,       // Value to forward from WB
  input  logic               i_alu_src,             // 1 selects the immediate
  input  logic               i_reg_dst,             // 1 selects rd
  input  alu_op_e            i_alu_op,
  input  logic               i_branch,
  input  logic               i_branch_prediction,
  output logic [`DATA_W-1:0] o_alu_result,
  output logic [`DATA_W-1:0] o_store_data,          // Forwarded rt for stores
  output logic [`REG_W-1:0]  o_write_register,
  output logic               o_branch_taken,
  output logic               o_mispredicted
);

  fwd_sel_e           forward_a;       // Source of operand A
  fwd_sel_e           forward_b;       // Source of operand B
  alu_ctrl_e          alu_ctrl;
  logic [`DATA_W-1:0] fwd_a;           // rs after forwarding
  logic [`DATA_W-1:0] fwd_b;           // rt after forwarding
  logic [`DATA_W-1:0] imm_ext;         // Sign-extended imm16
  logic [`DATA_W-1:0] alu_b;

  // Three-way operand mux, same for both sources
  function automatic logic [`DATA_W-1:0] fwd_mux(
    input fwd_sel_e           sel,
    input logic [`DATA_W-1:0] reg_val,
    input logic [`DATA_W-1:0] mem_val,
    input logic [`DATA_W-1:0] wb_val
  );
    logic [`DATA_W-1:0] val;
    case (sel)
      FWD_MEM: val = mem_val;
      FWD_WB:  val = wb_val;
      default: val = reg_val;          // FWD_REG and unused code
    endcase
    return val;
  endfunction

  forwarding_unit u_forwarding_unit (
    .i_ex_rs         (i_instr.r.rs),
    .i_ex_rt         (i_instr.r.rt),
    .i_mem_rd        (i_mem_write_register),
    .i_wb_rd         (i_wb_write_register),
    .i_mem_reg_write (i_mem_reg_write),
    .i_wb_reg_write  (i_wb_reg_write),
    .o_forward_a     (forward_a),
    .o_forward_b     (forward_b)
  );

  assign fwd_a = fwd_mux(forward_a, i_read_data_1, i_mem_alu_result, i_wb_write_data);
  assign fwd_b = fwd_mux(forward_b, i_read_data_2, i_mem_alu_result, i_wb_write_data);

  assign imm_ext      = {{(`DATA_W-16){i_instr.i.imm16[15]}}, i_instr.i.imm16};
  assign alu_b        = i_alu_src ? imm_ext : fwd_b;    // I-type uses the immediate
  assign o_store_data = fwd_b;                          // sw writes forwarded rt

  alu_control u_alu_control (
    .i_alu_op   (i_alu_op),
    .i_funct    (i_instr.r.funct),
    .o_alu_ctrl (alu_ctrl)
  );

  alu u_alu (
    .i_a        (fwd_a),
    .i_b        (alu_b),
    .i_alu_ctrl (alu_ctrl),
    .o_result   (o_alu_result)
  );

  assign o_write_register = i_reg_dst ? i_instr.r.rd : i_instr.i.rt;  // R-type writes rd

  // Compare on forwarded values so back-to-back dependencies resolve
  branch_resolver u_branch_resolver (
    .i_op_a              (fwd_a),
    .i_op_b              (fwd_b),
    .i_opcode            (i_instr.i.opcode),
    .i_branch            (i_branch),
    .i_branch_prediction (i_branch_prediction),
    .o_branch_taken      (o_branch_taken),
    .o_mispredicted      (o_mispredicted)
  );

endmodule

/* source/branch_resolver.sv */
`timescale 1ns/1ps
`include "mips_settings.svh"

module branch_resolver (
  input  logic [`DATA_W-1:0] i_op_a,               // Forwarded rs
  input  logic [`DATA_W-1:0] i_op_b,               // Forwarded rt, never the immediate
  input  logic [5:0]         i_opcode,             // Tells BEQ from BNE
  input  logic               i_branch,             // Instruction in EX is a branch
  input  logic               i_branch_prediction,  // 1 means predicted taken
  output logic               o_branch_taken,       // Actual outcome
  output logic               o_mispredicted        // Fetch must redirect
);

  logic is_equal;
  logic is_beq;
  logic is_bne;

  assign is_equal = (i_op_a == i_op_b);
  assign is_beq   = (i_opcode == `OPCODE_BEQ);
  assign is_bne   = (i_opcode == `OPCODE_BNE);

  // Any other opcode with the branch bit set resolves as not taken
  assign o_branch_taken = i_branch && ((is_beq && is_equal) || (is_bne && !is_equal));

  // Only real branches can be mispredicted
  assign o_mispredicted = i_branch && (o_branch_taken != i_branch_prediction);

endmodule

/* source/alu.sv */
`timescale 1ns/1ps
`include "mips_settings.svh"

module alu
  import mips_pkg::*;
(
  input  logic [`DATA_W-1:0] i_a,          // Operand A, forwarded rs
  input  logic [`DATA_W-1:0] i_b,          // Operand B, forwarded rt or immediate
  input  alu_ctrl_e          i_alu_ctrl,   // Operation select
  output logic [`DATA_W-1:0] o_result      // Combinational result
);

  logic [`DATA_W-1:0] sum;                 // Shared adder output
  logic [`DATA_W-1:0] diff;                // Shared subtractor output
  logic               less;                // Signed a < b

  assign sum  = i_a + i_b;                 // Wraps, no overflow trap
  assign diff = i_a - i_b;                 // Wraps as well
  assign less = ($signed(i_a) < $signed(i_b));

  always_comb begin
    case (i_alu_ctrl)
      ALU_AND: begin
        o_result = i_a & i_b;
      end
      ALU_OR: begin
        o_result = i_a | i_b;
      end
      ALU_ADD: begin
        o_result = sum;
      end
      ALU_SUB: begin
        o_result = diff;
      end
      ALU_SLT: begin
        o_result = {{(`DATA_W-1){1'b0}}, less};   // 1 or 0
      end
      ALU_NOR: begin
        o_result = ~(i_a | i_b);
      end
      default: begin
        o_result = sum;                    // Unused encodings behave as add
      end
    endcase
  end

endmodule

/* source/alu_control.sv */
`timescale 1ns/1ps
`include "mips_settings.svh"

module alu_control
  import mips_pkg::*;
(
  input  alu_op_e    i_alu_op,    // Class from the main decoder
  input  logic [5:0] i_funct,     // Function field, only meaningful for R-type
  output alu_ctrl_e  o_alu_ctrl   // Operation for the ALU
);

  // Second-level decode, classic two-step MIPS scheme
  always_comb begin
    case (i_alu_op)
      ALUOP_ADD: begin
        o_alu_ctrl = ALU_ADD;                 // Effective address
      end
      ALUOP_SUB: begin
        o_alu_ctrl = ALU_SUB;                 // Branch compare
      end
      ALUOP_SLT: begin
        o_alu_ctrl = ALU_SLT;                 // slti
      end
      ALUOP_FUNCT: begin
        case (i_funct)
          `FUNCT_ADD: o_alu_ctrl = ALU_ADD;
          `FUNCT_SUB: o_alu_ctrl = ALU_SUB;
          `FUNCT_AND: o_alu_ctrl = ALU_AND;
          `FUNCT_OR:  o_alu_ctrl = ALU_OR;
          `FUNCT_NOR: o_alu_ctrl = ALU_NOR;
          `FUNCT_SLT: o_alu_ctrl = ALU_SLT;
          default:    o_alu_ctrl = ALU_ADD;   // Unsupported funct falls back to add
        endcase
      end
      default: begin
        o_alu_ctrl = ALU_ADD;
      end
    endcase
  end

endmodule

/* source/forwarding_unit.sv */
`timescale 1ns/1ps
`include "mips_settings.svh"

module forwarding_unit
  import mips_pkg::*;
(
  input  logic [`REG_W-1:0] i_ex_rs,          // Source A of the instruction in EX
  input  logic [`REG_W-1:0] i_ex_rt,          // Source B of the instruction in EX
  input  logic [`REG_W-1:0] i_mem_rd,         // Destination held in EX/MEM
  input  logic [`REG_W-1:0] i_wb_rd,          // Destination held in MEM/WB
  input  logic              i_mem_reg_write,  // MEM will write its destination
  input  logic              i_wb_reg_write,   // WB will write its destination
  output fwd_sel_e          o_forward_a,      // Source select for operand A
  output fwd_sel_e          o_forward_b       // Source select for operand B
);

  // Youngest producer wins, $zero is never forwarded
  function automatic fwd_sel_e pick_src(
    input logic [`REG_W-1:0] src,
    input logic [`REG_W-1:0] mem_rd,
    input logic              mem_we,
    input logic [`REG_W-1:0] wb_rd,
    input logic              wb_we
  );
    fwd_sel_e sel;
    sel = FWD_REG;                                             // Default to register file
    if (mem_we && (mem_rd != '0) && (mem_rd == src)) begin
      sel = FWD_MEM;                                           // Hazard one instruction back
    end else if (wb_we && (wb_rd != '0) && (wb_rd == src)) begin
      sel = FWD_WB;                                            // Hazard two instructions back
    end
    return sel;
  endfunction

  assign o_forward_a = pick_src(i_ex_rs, i_mem_rd, i_mem_reg_write, i_wb_rd, i_wb_reg_write);
  assign o_forward_b = pick_src(i_ex_rt, i_mem_rd, i_mem_reg_write, i_wb_rd, i_wb_reg_write);

endmodule

/* source/mips_pkg.sv */
`include "mips_settings.svh"

package mips_pkg;

  // R-type layout of the instruction word
  typedef struct packed {
    logic [5:0]        opcode;      // Always OPCODE_RTYPE here
    logic [`REG_W-1:0] rs;          // First source
    logic [`REG_W-1:0] rt;          // Second source
    logic [`REG_W-1:0] rd;          // Destination
    logic [4:0]        shamt;       // Shift amount, no shifter in this stage
    logic [5:0]        funct;       // Selects the ALU operation
  } r_fmt_t;

  // I-type layout of the same word
  typedef struct packed {
    logic [5:0]        opcode;
    logic [`REG_W-1:0] rs;          // Base or first source
    logic [`REG_W-1:0] rt;          // Destination or second source
    logic [15:0]       imm16;       // Sign-extended in EX
  } i_fmt_t;

  // One 32-bit word, decoded either way
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
  } instr_u;

  // Operation class from the main decoder
  typedef enum logic [1:0] {
    ALUOP_ADD   = 2'b00,            // Loads and stores, address add
    ALUOP_SUB   = 2'b01,            // Branch compare
    ALUOP_FUNCT = 2'b10,            // R-type, look at funct
    ALUOP_SLT   = 2'b11             // slti
  } alu_op_e;

  // Operation driven into the ALU
  typedef enum logic [3:0] {
    ALU_AND = 4'b0000,
    ALU_OR  = 4'b0001,
    ALU_ADD = 4'b0010,
    ALU_SUB = 4'b0110,
    ALU_SLT = 4'b0111,
    ALU_NOR = 4'b1100
  } alu_ctrl_e;

  // Where an operand comes from
  typedef enum logic [1:0] {
    FWD_REG = 2'b00,                // Register file value from ID/EX
    FWD_MEM = 2'b01,                // ALU result sitting in EX/MEM
    FWD_WB  = 2'b10                 // Write-back data
  } fwd_sel_e;

endpackage

/* source/mips_settings.svh */
`ifndef MIPS_SETTINGS_SVH
`define MIPS_SETTINGS_SVH

// Datapath and register file geometry
`define DATA_W 32                   // Integer datapath width
`define REG_W  5                    // Register index, 32 registers

// Primary opcodes seen by the execute stage
`define OPCODE_RTYPE 6'h00          // All R-type share opcode 0
`define OPCODE_BEQ   6'h04          // Branch on equal
`define OPCODE_BNE   6'h05          // Branch on not equal

// R-type function field codes
`define FUNCT_ADD 6'h20
`define FUNCT_SUB 6'h22
`define FUNCT_AND 6'h24
`define FUNCT_OR  6'h25
`define FUNCT_NOR 6'h27
`define FUNCT_SLT 6'h2a             // Signed compare

`endif
